// File: dispatch_core.f
src/tomasula_pkg.sv
src/inst_decode.sv
src/inst_fifo.sv
src/iq.sv
src/rs_bank.sv
src/ldst_q.sv
src/rob.sv
src/dispatch_core.sv
verif/tb_dispatch_core.sv

// File: src/dispatch_core.sv
`timescale 1ns/1ps

module dispatch_core (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   fetch_valid_i,
    input  logic [31:0]            fetch_inst_i,
    output logic                   fetch_ready_o,
    input  logic                   mem_ack_i,
    output tomasula_pkg::rf_read_t rf_read_o,
    output tomasula_pkg::commit_t  commit_o
);

    logic                            dec_valid;
    logic                            fifo_ready;
    logic                            head_valid;
    logic                            yumi;
    logic [tomasula_pkg::NUM_RS-1:0] rs_free;
    logic [tomasula_pkg::NUM_RS-1:0] rs_load;
    logic                            ldst_full;
    logic                            ldst_load;
    logic                            rob_full;
    logic [2:0]                      rob_tag;
    logic                            rob_alloc;
    logic                            rs_req;
    logic [2:0]                      rs_tag;
    logic                            rs_grant;
    logic                            lq_req;
    logic [2:0]                      lq_tag;
    logic                            lq_grant;
    tomasula_pkg::ctl_word_t         dec_word;
    tomasula_pkg::ctl_word_t         head;
    tomasula_pkg::rs_entry_t         entry;

    inst_decode i_decode (
        .clk(clk), .rst_i(rst_i),
        .fetch_valid_i(fetch_valid_i), .fetch_inst_i(fetch_inst_i),
        .fetch_ready_o(fetch_ready_o),
        .dec_valid_o(dec_valid), .dec_word_o(dec_word), .dec_ready_i(fifo_ready)
    );

    inst_fifo i_fifo (
        .clk(clk), .rst_i(rst_i),
        .data_i(dec_word), .valid_i(dec_valid), .ready_o(fifo_ready),
        .valid_o(head_valid), .data_o(head), .yumi_i(yumi)
    );

    iq i_iq (
        .head_valid_i(head_valid), .head_i(head), .yumi_o(yumi),
        .rs_free_i(rs_free), .rs_load_o(rs_load),
        .ldst_full_i(ldst_full), .ldst_load_o(ldst_load),
        .rob_full_i(rob_full), .rob_tag_i(rob_tag), .rob_alloc_o(rob_alloc),
        .entry_o(entry), .rf_read_o(rf_read_o)
    );

    rs_bank i_rs_bank (
        .clk(clk), .rst_i(rst_i),
        .load_i(rs_load), .entry_i(entry), .free_o(rs_free),
        .cdb_req_o(rs_req), .cdb_req_tag_o(rs_tag), .cdb_grant_i(rs_grant)
    );

    ldst_q i_ldst_q (
        .clk(clk), .rst_i(rst_i),
        .load_i(ldst_load), .entry_i(entry), .full_o(ldst_full),
        .mem_ack_i(mem_ack_i),
        .cdb_req_o(lq_req), .cdb_req_tag_o(lq_tag), .cdb_grant_i(lq_grant)
    );

    rob i_rob (
        .clk(clk), .rst_i(rst_i),
        .alloc_i(rob_alloc), .alloc_word_i(head), .full_o(rob_full), .tag_o(rob_tag),
        .rs_req_i(rs_req), .rs_tag_i(rs_tag), .rs_grant_o(rs_grant),
        .lq_req_i(lq_req), .lq_tag_i(lq_tag), .lq_grant_o(lq_grant),
        .commit_o(commit_o)
    );

endmodule : dispatch_core

// File: src/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   fetch_valid_i,
    input  logic [31:0]            fetch_inst_i,
    output logic                   fetch_ready_o,
    output logic                   dec_valid_o,
    output tomasula_pkg::ctl_word_t dec_word_o,
    input  logic                   dec_ready_i
);

    tomasula_pkg::ctl_word_t word;

    // take a new word when the stage is empty or drains this cycle
    assign fetch_ready_o = !dec_valid_o || dec_ready_i;

    always_comb begin
        word.op       = tomasula_pkg::OP_ALU;
        word.rd       = fetch_inst_i[11:7];
        word.src1_reg = fetch_inst_i[19:15];
        word.src2_reg = fetch_inst_i[24:20];
        word.funct3   = fetch_inst_i[14:12];

        case (fetch_inst_i[6:0])
            tomasula_pkg::RV_OP: begin
                // r-type keeps every field
                word.op = tomasula_pkg::OP_ALU;
            end
            tomasula_pkg::RV_OP_IMM: begin
                word.src2_reg = 5'd0;
            end
            tomasula_pkg::RV_LUI, tomasula_pkg::RV_AUIPC: begin
                word.src1_reg = 5'd0;
                word.src2_reg = 5'd0;
                word.funct3   = 3'd0;
            end
            tomasula_pkg::RV_LOAD: begin
                word.op       = tomasula_pkg::OP_LOAD;
                word.src2_reg = 5'd0;
            end
            tomasula_pkg::RV_STORE: begin
                word.op = tomasula_pkg::OP_STORE;
                word.rd = 5'd0;
            end
            tomasula_pkg::RV_BRANCH: begin
                word.op = tomasula_pkg::OP_BRANCH;
                word.rd = 5'd0;
            end
            tomasula_pkg::RV_JAL: begin
                // jumps still write the link register
                word.op       = tomasula_pkg::OP_BRANCH;
                word.src1_reg = 5'd0;
                word.src2_reg = 5'd0;
                word.funct3   = 3'd0;
            end
            tomasula_pkg::RV_JALR: begin
                word.op       = tomasula_pkg::OP_BRANCH;
                word.src2_reg = 5'd0;
            end
            default: begin
                // unknown word retires as an alu op with no operands
                word.rd       = 5'd0;
                word.src1_reg = 5'd0;
                word.src2_reg = 5'd0;
                word.funct3   = 3'd0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dec_valid_o <= 1'b0;
        end else if (fetch_ready_o) begin
            dec_valid_o <= fetch_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ready_o && fetch_valid_i) begin
            dec_word_o <= word;
        end
    end

endmodule : inst_decode

// File: src/inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo (
    input  logic                    clk,
    input  logic                    rst_i,
    input  tomasula_pkg::ctl_word_t data_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    output logic                    valid_o,
    output tomasula_pkg::ctl_word_t data_o,
    input  logic                    yumi_i
);

    tomasula_pkg::ctl_word_t mem [tomasula_pkg::IQ_DEPTH];

    logic [tomasula_pkg::IQ_PTR_W-1:0] wr_ptr;
    logic [tomasula_pkg::IQ_PTR_W-1:0] rd_ptr;
    logic [tomasula_pkg::IQ_PTR_W:0]   count;
    logic                              push;
    logic                              pop;

    // a full queue refuses a write even if the head leaves this cycle
    assign ready_o = (count != tomasula_pkg::IQ_DEPTH);
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];

    assign push = valid_i && ready_o;
    assign pop  = yumi_i && valid_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule : inst_fifo

// File: src/iq.sv
`timescale 1ns/1ps

module iq (
    input  logic                              head_valid_i,
    input  tomasula_pkg::ctl_word_t           head_i,
    output logic                              yumi_o,
    input  logic [tomasula_pkg::NUM_RS-1:0]   rs_free_i,
    output logic [tomasula_pkg::NUM_RS-1:0]   rs_load_o,
    input  logic                              ldst_full_i,
    output logic                              ldst_load_o,
    input  logic                              rob_full_i,
    input  logic [2:0]                        rob_tag_i,
    output logic                              rob_alloc_o,
    output tomasula_pkg::rs_entry_t           entry_o,
    output tomasula_pkg::rf_read_t            rf_read_o
);

    logic                            is_mem;
    logic                            issue_mem;
    logic                            issue_alu;
    logic [tomasula_pkg::NUM_RS-1:0] pick;

    always_comb begin
        is_mem = (head_i.op == tomasula_pkg::OP_LOAD) ||
                 (head_i.op == tomasula_pkg::OP_STORE);

        // lowest set bit of the free vector, so station 0 wins
        pick = rs_free_i & (~rs_free_i + 1'b1);

        // memory ops go to the load/store queue, everything else to a station
        issue_mem = head_valid_i && is_mem && !ldst_full_i && !rob_full_i;
        issue_alu = head_valid_i && !is_mem && (|rs_free_i) && !rob_full_i;

        yumi_o      = issue_mem || issue_alu;
        ldst_load_o = issue_mem;
        rs_load_o   = issue_alu ? pick : '0;

        // a rob slot is taken exactly when the head leaves
        rob_alloc_o = yumi_o;
    end

    always_comb begin
        entry_o.ctl = head_i;
        entry_o.tag = rob_tag_i;

        rf_read_o.valid    = yumi_o;
        rf_read_o.src1_reg = head_i.src1_reg;
        rf_read_o.src2_reg = head_i.src2_reg;
    end

endmodule : iq

// File: src/ldst_q.sv
`timescale 1ns/1ps

module ldst_q (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    load_i,
    input  tomasula_pkg::rs_entry_t entry_i,
    output logic                    full_o,
    input  logic                    mem_ack_i,
    output logic                    cdb_req_o,
    output logic [2:0]              cdb_req_tag_o,
    input  logic                    cdb_grant_i
);

    tomasula_pkg::rs_entry_t             q [tomasula_pkg::LDST_DEPTH];
    logic [tomasula_pkg::LDST_DEPTH-1:0] valid;
    logic [tomasula_pkg::LDST_DEPTH-1:0] acked;
    logic [tomasula_pkg::LDST_PTR_W-1:0] head;
    logic [tomasula_pkg::LDST_PTR_W-1:0] tail;
    logic [tomasula_pkg::LDST_PTR_W-1:0] ack_ptr;
    logic                                take_ack;

    // tail slot still occupied means every slot is taken
    assign full_o        = valid[tail];
    assign cdb_req_o     = valid[head] && acked[head];
    assign cdb_req_tag_o = q[head].tag;

    // acks arrive in order, so ack_ptr marks the oldest waiting entry
    assign take_ack = mem_ack_i && valid[ack_ptr] && !acked[ack_ptr];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid   <= '0;
            acked   <= '0;
            head    <= '0;
            tail    <= '0;
            ack_ptr <= '0;
        end else begin
            if (load_i && !full_o) begin
                valid[tail] <= 1'b1;
                acked[tail] <= 1'b0;
                tail        <= tail + 1'b1;
            end
            if (take_ack) begin
                acked[ack_ptr] <= 1'b1;
                ack_ptr        <= ack_ptr + 1'b1;
            end
            if (cdb_req_o && cdb_grant_i) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i && !full_o) begin
            q[tail] <= entry_i;
        end
    end

endmodule : ldst_q

// File: src/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    alloc_i,
    input  tomasula_pkg::ctl_word_t alloc_word_i,
    output logic                    full_o,
    output logic [2:0]              tag_o,
    input  logic                    rs_req_i,
    input  logic [2:0]              rs_tag_i,
    output logic                    rs_grant_o,
    input  logic                    lq_req_i,
    input  logic [2:0]              lq_tag_i,
    output logic                    lq_grant_o,
    output tomasula_pkg::commit_t   commit_o
);

    tomasula_pkg::op_e                  entry_op   [tomasula_pkg::ROB_DEPTH];
    logic [4:0]                         entry_rd   [tomasula_pkg::ROB_DEPTH];
    logic [tomasula_pkg::ROB_DEPTH-1:0] entry_done;
    logic [tomasula_pkg::ROB_TAG_W-1:0] head;
    logic [tomasula_pkg::ROB_TAG_W-1:0] tail;
    logic [tomasula_pkg::ROB_TAG_W:0]   count;
    tomasula_pkg::cdb_t                 cdb;
    logic                               do_alloc;
    logic                               do_commit;

    assign full_o = (count == tomasula_pkg::ROB_DEPTH);
    assign tag_o  = tail;

    // stations beat the load/store queue for the single bus
    assign rs_grant_o = rs_req_i;
    assign lq_grant_o = lq_req_i && !rs_req_i;
    assign cdb.valid  = rs_req_i || lq_req_i;
    assign cdb.tag    = rs_req_i ? rs_tag_i : lq_tag_i;

    assign do_alloc  = alloc_i && !full_o;
    assign do_commit = (count != '0) && entry_done[head];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            commit_o.valid  <= 1'b0;
        end else begin
            if (do_alloc) begin
                tail <= tail + 1'b1;
            end
            if (do_commit) begin
                head <= head + 1'b1;
            end
            if (do_alloc && !do_commit) begin
                count <= count + 1'b1;
            end else if (do_commit && !do_alloc) begin
                count <= count - 1'b1;
            end
            commit_o <= '{valid: do_commit, tag: head, op: entry_op[head], rd: entry_rd[head]};
        end
    end

    // done bits only mean something while count covers the entry
    always_ff @(posedge clk) begin
        if (do_alloc) begin
            entry_op[tail]   <= alloc_word_i.op;
            entry_rd[tail]   <= alloc_word_i.rd;
            entry_done[tail] <= 1'b0;
        end
        if (cdb.valid) begin
            entry_done[cdb.tag] <= 1'b1;
        end
    end

endmodule : rob

// File: src/rs_bank.sv
`timescale 1ns/1ps

module rs_bank (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic [tomasula_pkg::NUM_RS-1:0] load_i,
    input  tomasula_pkg::rs_entry_t         entry_i,
    output logic [tomasula_pkg::NUM_RS-1:0] free_o,
    output logic                            cdb_req_o,
    output logic [2:0]                      cdb_req_tag_o,
    input  logic                            cdb_grant_i
);

    logic [tomasula_pkg::NUM_RS-1:0]     busy;
    logic [tomasula_pkg::NUM_RS-1:0]     ready;
    logic [tomasula_pkg::NUM_RS-1:0]     grant_vec;
    logic [tomasula_pkg::RS_IDX_W-1:0]   sel;
    tomasula_pkg::rs_entry_t             ent [tomasula_pkg::NUM_RS];
    logic [tomasula_pkg::EXEC_CNT_W-1:0] cnt [tomasula_pkg::NUM_RS];

    assign free_o = ~busy;

    always_comb begin
        ready = '0;
        sel   = '0;
        for (int i = 0; i < tomasula_pkg::NUM_RS; i++) begin
            ready[i] = busy[i] && (cnt[i] == '0);
        end
        // walk down so the lowest ready station is the one left in sel
        for (int i = tomasula_pkg::NUM_RS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel = tomasula_pkg::RS_IDX_W'(i);
            end
        end
    end

    assign cdb_req_o     = |ready;
    assign cdb_req_tag_o = ent[sel].tag;
    assign grant_vec     = cdb_grant_i ? (ready & (~ready + 1'b1)) : '0;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy <= '0;
        end else begin
            for (int i = 0; i < tomasula_pkg::NUM_RS; i++) begin
                if (load_i[i]) begin
                    busy[i] <= 1'b1;
                end else if (grant_vec[i]) begin
                    busy[i] <= 1'b0;
                end
            end
        end
    end

    // countdown starts at load and parks at zero until the grant
    always_ff @(posedge clk) begin
        for (int i = 0; i < tomasula_pkg::NUM_RS; i++) begin
            if (load_i[i]) begin
                ent[i] <= entry_i;
                cnt[i] <= tomasula_pkg::EXEC_CNT_W'(tomasula_pkg::EXEC_CYCLES);
            end else if (busy[i] && (cnt[i] != '0)) begin
                cnt[i] <= cnt[i] - 1'b1;
            end
        end
    end

endmodule : rs_bank

// File: src/tomasula_pkg.sv
package tomasula_pkg;

    // queue and buffer sizes
    localparam int IQ_DEPTH    = 4;
    localparam int IQ_PTR_W    = $clog2(IQ_DEPTH);
    localparam int ROB_DEPTH   = 8;
    localparam int ROB_TAG_W   = $clog2(ROB_DEPTH);
    localparam int LDST_DEPTH  = 4;
    localparam int LDST_PTR_W  = $clog2(LDST_DEPTH);
    localparam int NUM_RS      = 4;
    localparam int RS_IDX_W    = $clog2(NUM_RS);

    // cycles an alu station holds before asking for the cdb
    localparam int EXEC_CYCLES = 2;
    localparam int EXEC_CNT_W  = $clog2(EXEC_CYCLES + 1);

    // rv32i major opcodes seen by decode
    typedef enum logic [6:0] {
        RV_LUI    = 7'b0110111,
        RV_AUIPC  = 7'b0010111,
        RV_JAL    = 7'b1101111,
        RV_JALR   = 7'b1100111,
        RV_BRANCH = 7'b1100011,
        RV_LOAD   = 7'b0000011,
        RV_STORE  = 7'b0100011,
        RV_OP_IMM = 7'b0010011,
        RV_OP     = 7'b0110011
    } rv_opcode_e;

    // class of work the back end does with an instruction
    typedef enum logic [1:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH
    } op_e;

    typedef struct packed {
        op_e        op;
        logic [4:0] rd;
        logic [4:0] src1_reg;
        logic [4:0] src2_reg;
        logic [2:0] funct3;
    } ctl_word_t;

    typedef struct packed {
        ctl_word_t              ctl;
        logic [ROB_TAG_W-1:0]   tag;
    } rs_entry_t;

    typedef struct packed {
        logic                   valid;
        logic [ROB_TAG_W-1:0]   tag;
    } cdb_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] src1_reg;
        logic [4:0] src2_reg;
    } rf_read_t;

    typedef struct packed {
        logic                   valid;
        logic [ROB_TAG_W-1:0]   tag;
        op_e                    op;
        logic [4:0]             rd;
    } commit_t;

endpackage : tomasula_pkg

// File: verif/tb_dispatch_core.sv
`timescale 1ns/1ps

module tb_dispatch_core;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int NUM_ROWS       = 17;
    localparam int STALL_WORDS    = 10;

    typedef struct packed {
        logic [31:0]       inst;
        tomasula_pkg::op_e op;
        logic [4:0]        rd;
        logic [4:0]        src1;
        logic [4:0]        src2;
    } row_t;

    logic                   clk = 1'b0;
    logic                   rst_i;
    logic                   fetch_valid_i;
    logic [31:0]            fetch_inst_i;
    logic                   fetch_ready_o;
    logic                   mem_ack_i;
    tomasula_pkg::rf_read_t rf_read_o;
    tomasula_pkg::commit_t  commit_o;

    row_t                   rows [NUM_ROWS];
    tomasula_pkg::commit_t  exp_commit [$];
    tomasula_pkg::rf_read_t exp_rf [$];
    logic [2:0]             next_tag;
    integer                 seed = 87;
    int                     errors = 0;
    int                     pass_cnt = 0;
    int                     fail_cnt = 0;
    int                     acks_sent;
    int                     mem_commits;
    logic                   ack_en;
    logic                   stall_seen;

    dispatch_core i_dut (
        .clk(clk), .rst_i(rst_i),
        .fetch_valid_i(fetch_valid_i), .fetch_inst_i(fetch_inst_i),
        .fetch_ready_o(fetch_ready_o), .mem_ack_i(mem_ack_i),
        .rf_read_o(rf_read_o), .commit_o(commit_o)
    );

    always #5 clk = ~clk;

    // random acknowledge pulses for the load/store queue
    always @(posedge clk) begin
        if (rst_i || !ack_en) begin
            mem_ack_i <= 1'b0;
        end else begin
            mem_ack_i <= ($random(seed) & 1) != 0;
        end
    end

    task automatic load_table();
        // alu, lui and branch words ending in one that is not rv32i
        rows[0]  = '{32'h002081B3, tomasula_pkg::OP_ALU,    5'd3,  5'd1,  5'd2};
        rows[1]  = '{32'h00C30293, tomasula_pkg::OP_ALU,    5'd5,  5'd6,  5'd0};
        rows[2]  = '{32'h123453B7, tomasula_pkg::OP_ALU,    5'd7,  5'd0,  5'd0};
        rows[3]  = '{32'h00208463, tomasula_pkg::OP_BRANCH, 5'd0,  5'd1,  5'd2};
        rows[4]  = '{32'h40940533, tomasula_pkg::OP_ALU,    5'd10, 5'd8,  5'd9};
        rows[5]  = '{32'h00001597, tomasula_pkg::OP_ALU,    5'd11, 5'd0,  5'd0};
        rows[6]  = '{32'h010000EF, tomasula_pkg::OP_BRANCH, 5'd1,  5'd0,  5'd0};
        rows[7]  = '{32'h00008067, tomasula_pkg::OP_BRANCH, 5'd0,  5'd1,  5'd0};
        rows[8]  = '{32'hFFFFFFFF, tomasula_pkg::OP_ALU,    5'd0,  5'd0,  5'd0};
        // memory ops mixed with alu work
        rows[9]  = '{32'h00412603, tomasula_pkg::OP_LOAD,   5'd12, 5'd2,  5'd0};
        rows[10] = '{32'h003606B3, tomasula_pkg::OP_ALU,    5'd13, 5'd12, 5'd3};
        rows[11] = '{32'h00D12423, tomasula_pkg::OP_STORE,  5'd0,  5'd2,  5'd13};
        rows[12] = '{32'h00170713, tomasula_pkg::OP_ALU,    5'd14, 5'd14, 5'd0};
        rows[13] = '{32'h00008783, tomasula_pkg::OP_LOAD,   5'd15, 5'd1,  5'd0};
        rows[14] = '{32'h00F74833, tomasula_pkg::OP_ALU,    5'd16, 5'd14, 5'd15};
        rows[15] = '{32'h01019123, tomasula_pkg::OP_STORE,  5'd0,  5'd3,  5'd16};
        rows[16] = '{32'h00506893, tomasula_pkg::OP_ALU,    5'd17, 5'd0,  5'd0};
    endtask

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic check_commit(input string name, input tomasula_pkg::commit_t got,
                                input tomasula_pkg::commit_t exp);
        if (got.valid !== exp.valid || (exp.valid && (got.tag !== exp.tag ||
                got.op !== exp.op || got.rd !== exp.rd))) begin
            errors++;
            $display("** Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_rf_read(input string name, input tomasula_pkg::rf_read_t got,
                                 input tomasula_pkg::rf_read_t exp);
        if (got.valid !== exp.valid || (exp.valid && (got.src1_reg !== exp.src1_reg ||
                got.src2_reg !== exp.src2_reg))) begin
            errors++;
            $display("** Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic apply_reset();
        rst_i         <= 1'b1;
        fetch_valid_i <= 1'b0;
        repeat (3) @(posedge clk);
        exp_commit.delete();
        exp_rf.delete();
        next_tag    = '0;
        acks_sent   = 0;
        mem_commits = 0;
        rst_i <= 1'b0;
    endtask

    task automatic clear_ack_count();
        @(posedge clk);
        acks_sent   = 0;
        mem_commits = 0;
    endtask

    task automatic send_word(input int row);
        int                     waited;
        tomasula_pkg::commit_t  exp_c;
        tomasula_pkg::rf_read_t exp_r;
        waited = 0;
        @(posedge clk);
        fetch_valid_i <= 1'b1;
        fetch_inst_i  <= rows[row].inst;
        @(negedge clk);
        while (!fetch_ready_o && waited < TIMEOUT_CYCLES) begin
            // machine is full so let the memory side drain again
            stall_seen = 1'b1;
            ack_en     = 1'b1;
            @(negedge clk);
            waited++;
        end
        if (!fetch_ready_o) begin
            report_timeout("the fetch handshake");
        end
        @(posedge clk);
        fetch_valid_i <= 1'b0;
        exp_c.valid    = 1'b1;
        exp_c.tag      = next_tag;
        exp_c.op       = rows[row].op;
        exp_c.rd       = rows[row].rd;
        exp_r.valid    = 1'b1;
        exp_r.src1_reg = rows[row].src1;
        exp_r.src2_reg = rows[row].src2;
        exp_commit.push_back(exp_c);
        exp_rf.push_back(exp_r);
        next_tag = next_tag + 1'b1;
    endtask

    task automatic wait_issue(input string what);
        int waited;
        waited = 0;
        while (exp_rf.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_rf.size() != 0) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while ((exp_commit.size() != 0 || exp_rf.size() != 0) && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (exp_commit.size() != 0 || exp_rf.size() != 0) begin
            report_timeout(what);
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        if (errors == err_start) begin
            pass_cnt++;
            $display("test %0d %s: ok", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", num, name, errors - err_start);
        end
    endtask

    // commits and register reads are checked against program order
    always @(negedge clk) begin : monitor
        tomasula_pkg::commit_t  exp_c;
        tomasula_pkg::rf_read_t exp_r;
        if (!rst_i) begin
            if (mem_ack_i) begin
                acks_sent++;
            end
            if (commit_o.valid) begin
                if (exp_commit.size() == 0) begin
                    errors++;
                    $display("a commit with tag %h appeared with nothing in flight",
                             commit_o.tag);
                end else begin
                    exp_c = exp_commit.pop_front();
                    check_commit("commit_o", commit_o, exp_c);
                    if (exp_c.op == tomasula_pkg::OP_LOAD ||
                            exp_c.op == tomasula_pkg::OP_STORE) begin
                        mem_commits++;
                        if (acks_sent < mem_commits) begin
                            errors++;
                            $display("memory op %0d committed after only %0d acknowledges",
                                     mem_commits, acks_sent);
                        end
                    end
                end
            end
            if (rf_read_o.valid) begin
                if (exp_rf.size() == 0) begin
                    errors++;
                    $display("a register read appeared with nothing waiting to issue");
                end else begin
                    exp_r = exp_rf.pop_front();
                    check_rf_read("rf_read_o", rf_read_o, exp_r);
                end
            end
        end
    end

    initial begin : main
        int err_start;
        rst_i         = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_inst_i  = '0;
        mem_ack_i     = 1'b0;
        ack_en        = 1'b1;
        stall_seen    = 1'b0;
        load_table();
        apply_reset();

        err_start = errors;
        @(negedge clk);
        check_commit("commit_o", commit_o, '0);
        check_rf_read("rf_read_o", rf_read_o, '0);
        check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
        for (int i = 0; i < 4; i++) begin
            send_word(i);
        end
        apply_reset();
        // nothing may retire while the machine sits empty
        repeat (30) @(negedge clk);
        check_commit("commit_o", commit_o, '0);
        check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
        report_test(1, "reset", err_start);

        err_start = errors;
        for (int i = 0; i <= 8; i++) begin
            send_word(i);
        end
        wait_drain("the alu stream to commit");
        report_test(2, "alu and branch stream", err_start);

        err_start = errors;
        for (int i = 8; i >= 0; i--) begin
            send_word(i);
        end
        wait_drain("the register reads to finish");
        report_test(3, "register read order", err_start);

        err_start = errors;
        // acknowledges stay off until every word sits in a station or the queue
        ack_en = 1'b0;
        clear_ack_count();
        for (int i = 9; i < NUM_ROWS; i++) begin
            send_word(i);
        end
        wait_issue("the mixed stream to issue");
        ack_en = 1'b1;
        wait_drain("the mixed stream to commit");
        report_test(4, "loads and stores mixed with alu", err_start);

        err_start  = errors;
        ack_en     = 1'b0;
        stall_seen = 1'b0;
        clear_ack_count();
        for (int i = 0; i < STALL_WORDS; i++) begin
            send_word(9 + 2 * (i % 4));
        end
        wait_drain("the memory words to commit");
        if (!stall_seen) begin
            errors++;
            $display("fetch_ready_o never fell while acknowledges were held low");
        end
        ack_en = 1'b1;
        report_test(5, "back-pressure", err_start);

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (errors == 0 && fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : tb_dispatch_core
